// File: all.f
common/cpu_pkg.sv
verilog/fetch_stage.sv
decode/register_file.sv
decode/decode_stage.sv
execute/execute_stage.sv
memory/memory_stage.sv
verilog/cpu_top.sv
verification/cpu_tb_assert.sv
verification/cpu_tb.sv

// File: common/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    localparam int DATA_W = 8;                  // machine word width

    typedef logic [DATA_W-1:0] data_t;          // data or instruction word
    typedef logic [1:0]        reg_idx_t;       // one of four registers
    typedef logic [3:0]        opcode_t;        // instr[7:4]
    typedef logic [1:0]        wb_sel_t;        // writeback source

    // opcode map
    localparam opcode_t OP_NOP = 4'd0;
    localparam opcode_t OP_MOV = 4'd1;
    localparam opcode_t OP_ADD = 4'd2;
    localparam opcode_t OP_SUB = 4'd3;
    localparam opcode_t OP_AND = 4'd4;
    localparam opcode_t OP_OR  = 4'd5;
    localparam opcode_t OP_IN  = 4'd6;
    localparam opcode_t OP_OUT = 4'd7;
    localparam opcode_t OP_LDM = 4'd8;          // two-word immediate load
    localparam opcode_t OP_LDD = 4'd9;
    localparam opcode_t OP_STD = 4'd10;         // 11..15 behave as NOP

    localparam wb_sel_t WB_ALU    = 2'd0;       // alu result
    localparam wb_sel_t WB_MEM    = 2'd1;       // data memory
    localparam wb_sel_t WB_IMM_IN = 2'd2;       // immediate or in_port sample

    typedef struct packed {
        logic     valid;
        data_t    instr;
        data_t    in_sample;                    // in_port at accept time
    } if_id_t;

    typedef struct packed {
        logic     valid;
        opcode_t  opcode;
        reg_idx_t ra;                           // also the destination
        reg_idx_t rb;
        data_t    ra_val;
        data_t    rb_val;
        data_t    imm;                          // LDM immediate or IN sample
        logic     reg_write;
        logic     mem_read;
        logic     mem_write;
        logic     out_write;
        wb_sel_t  wb_sel;
    } id_ex_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t dst;
        data_t    result;                       // alu out, address or out value
        data_t    store_data;
        logic     reg_write;
        logic     mem_read;
        logic     mem_write;
        logic     out_write;
    } ex_mem_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t dst;
        data_t    result;
        data_t    load_data;                    // dmem read, aligned with this reg
        logic     reg_write;
        logic     mem_read;
        logic     out_write;
    } mem_wb_t;

endpackage

`default_nettype wire

// File: decode/decode_stage.sv
`timescale 1ns/1ns
`default_nettype none

module decode_stage import cpu_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  if_id_t   if_id,
    output logic     hold,
    output reg_idx_t rd_idx_a,
    output reg_idx_t rd_idx_b,
    input  data_t    rd_data_a,
    input  data_t    rd_data_b,
    output id_ex_t   id_ex
);

    typedef enum logic {
        DEC_OP,                                 // expecting an opcode word
        DEC_IMM                                 // expecting LDM immediate
    } dec_state_e;

    dec_state_e state;
    dec_state_e state_nxt;
    reg_idx_t   ldm_ra;                         // dest of pending LDM
    opcode_t    op;
    reg_idx_t   ra;
    reg_idx_t   rb;
    logic       load_use;
    id_ex_t     id_ex_nxt;

    assign op = if_id.instr[7:4];
    assign ra = if_id.instr[3:2];
    assign rb = if_id.instr[1:0];

    assign rd_idx_a = ra;
    assign rd_idx_b = rb;

    // load in EX writes a reg this word names
    assign load_use = id_ex.valid && id_ex.mem_read &&
                      (id_ex.ra == ra || id_ex.ra == rb);
    assign hold     = if_id.valid && (state == DEC_OP) && load_use;

    always_comb begin
        id_ex_nxt = '0;                         // bubble unless issued
        state_nxt = state;
        if (if_id.valid && !hold) begin
            if (state == DEC_IMM) begin
                // second LDM word is the value itself
                id_ex_nxt.valid     = 1'b1;
                id_ex_nxt.opcode    = OP_LDM;
                id_ex_nxt.ra        = ldm_ra;
                id_ex_nxt.imm       = if_id.instr;
                id_ex_nxt.reg_write = 1'b1;
                id_ex_nxt.wb_sel    = WB_IMM_IN;
                state_nxt           = DEC_OP;
            end else if (op == OP_LDM) begin
                state_nxt = DEC_IMM;            // first word only leaves a bubble
            end else begin
                id_ex_nxt.valid  = 1'b1;
                id_ex_nxt.opcode = op;
                id_ex_nxt.ra     = ra;
                id_ex_nxt.rb     = rb;
                id_ex_nxt.ra_val = rd_data_a;
                id_ex_nxt.rb_val = rd_data_b;
                id_ex_nxt.imm    = if_id.in_sample;
                id_ex_nxt.wb_sel = WB_ALU;
                case (op)
                    OP_MOV, OP_ADD, OP_SUB, OP_AND, OP_OR: begin
                        id_ex_nxt.reg_write = 1'b1;
                    end
                    OP_IN: begin
                        id_ex_nxt.reg_write = 1'b1;
                        id_ex_nxt.wb_sel    = WB_IMM_IN;
                    end
                    OP_OUT: id_ex_nxt.out_write = 1'b1;
                    OP_LDD: begin
                        id_ex_nxt.reg_write = 1'b1;
                        id_ex_nxt.mem_read  = 1'b1;
                        id_ex_nxt.wb_sel    = WB_MEM;
                    end
                    OP_STD: id_ex_nxt.mem_write = 1'b1;
                    default: id_ex_nxt.opcode = OP_NOP;  // 0 and 11..15
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= DEC_OP;
            ldm_ra <= '0;
            id_ex  <= '0;
        end else begin
            state <= state_nxt;
            id_ex <= id_ex_nxt;
            if (state == DEC_OP && state_nxt == DEC_IMM) begin
                ldm_ra <= ra;                   // remember LDM target
            end
        end
    end

endmodule

`default_nettype wire

// File: decode/register_file.sv
`timescale 1ns/1ns
`default_nettype none

module register_file import cpu_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  reg_idx_t rd_idx_a,
    input  reg_idx_t rd_idx_b,
    output data_t    rd_data_a,
    output data_t    rd_data_b,
    input  logic     wb_en,
    input  reg_idx_t wb_idx,
    input  data_t    wb_data
);

    data_t regs [4];                            // r0..r3

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 4; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en) begin
            regs[wb_idx] <= wb_data;
        end
    end

    // write-first: a same-cycle writeback wins over the stored value
    assign rd_data_a = (wb_en && wb_idx == rd_idx_a) ? wb_data : regs[rd_idx_a];
    assign rd_data_b = (wb_en && wb_idx == rd_idx_b) ? wb_data : regs[rd_idx_b];

endmodule

`default_nettype wire

// File: execute/execute_stage.sv
`timescale 1ns/1ns
`default_nettype none

module execute_stage import cpu_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  id_ex_t  id_ex,
    input  mem_wb_t mem_wb,                     // older result for forwarding
    output ex_mem_t ex_mem
);

    data_t a_fwd;                               // ra after forwarding
    data_t b_fwd;                               // rb after forwarding
    data_t alu_res;
    data_t result;

    // newest producer first; a load in EX/MEM has no data yet
    function automatic data_t fwd(input reg_idx_t idx, input data_t dec_val);
        data_t val;
        val = dec_val;
        if (ex_mem.valid && ex_mem.reg_write && !ex_mem.mem_read &&
            ex_mem.dst == idx) begin
            val = ex_mem.result;
        end else if (mem_wb.valid && mem_wb.reg_write && mem_wb.dst == idx) begin
            val = mem_wb.mem_read ? mem_wb.load_data : mem_wb.result;
        end
        return val;
    endfunction

    always_comb begin
        a_fwd = fwd(id_ex.ra, id_ex.ra_val);
        b_fwd = fwd(id_ex.rb, id_ex.rb_val);
    end

    always_comb begin
        case (id_ex.opcode)
            OP_ADD:  alu_res = a_fwd + b_fwd;   // wraps mod 256
            OP_SUB:  alu_res = a_fwd - b_fwd;
            OP_AND:  alu_res = a_fwd & b_fwd;
            OP_OR:   alu_res = a_fwd | b_fwd;
            default: alu_res = b_fwd;           // MOV, OUT value, LDD/STD address
        endcase
    end

    // LDM and IN bypass the alu
    assign result = (id_ex.wb_sel == WB_IMM_IN) ? id_ex.imm : alu_res;

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_mem <= '0;
        end else begin
            ex_mem.valid      <= id_ex.valid;
            ex_mem.dst        <= id_ex.ra;
            ex_mem.result     <= result;
            ex_mem.store_data <= a_fwd;         // STD writes ra
            ex_mem.reg_write  <= id_ex.reg_write;
            ex_mem.mem_read   <= id_ex.mem_read;
            ex_mem.mem_write  <= id_ex.mem_write;
            ex_mem.out_write  <= id_ex.out_write;
        end
    end

endmodule

`default_nettype wire

// File: memory/memory_stage.sv
`timescale 1ns/1ns
`default_nettype none

module memory_stage import cpu_pkg::*; #(
    parameter int DMEM_ADDR_W = 8
) (
    input  logic     clk,
    input  logic     rst,
    input  ex_mem_t  ex_mem,
    output mem_wb_t  mem_wb,
    output logic     wb_en,
    output reg_idx_t wb_idx,
    output data_t    wb_data,
    output logic     out_valid,
    output data_t    out_data
);

    localparam int DMEM_DEPTH = 1 << DMEM_ADDR_W;

    data_t                  dmem [DMEM_DEPTH];
    logic [DMEM_ADDR_W-1:0] addr;               // low bits of the rb value

    assign addr = DMEM_ADDR_W'(ex_mem.result);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < DMEM_DEPTH; i++) begin
                dmem[i] <= '0;
            end
        end else if (ex_mem.valid && ex_mem.mem_write) begin
            dmem[addr] <= ex_mem.store_data;
        end
    end

    // sync read lands in MEM/WB together with the rest
    always_ff @(posedge clk) begin
        if (rst) begin
            mem_wb <= '0;
        end else begin
            mem_wb.valid     <= ex_mem.valid;
            mem_wb.dst       <= ex_mem.dst;
            mem_wb.result    <= ex_mem.result;
            mem_wb.load_data <= dmem[addr];
            mem_wb.reg_write <= ex_mem.reg_write;
            mem_wb.mem_read  <= ex_mem.mem_read;
            mem_wb.out_write <= ex_mem.out_write;
        end
    end

    // writeback select
    assign wb_en   = mem_wb.valid && mem_wb.reg_write;
    assign wb_idx  = mem_wb.dst;
    assign wb_data = mem_wb.mem_read ? mem_wb.load_data : mem_wb.result;

    // out port keeps the last value between strobes
    always_ff @(posedge clk) begin
        if (rst) begin
            out_data <= '0;
        end else if (ex_mem.valid && ex_mem.out_write) begin
            out_data <= ex_mem.result;
        end
    end

    assign out_valid = mem_wb.valid && mem_wb.out_write;  // one beat per OUT

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# build cpu_tb with Verilator, run it, then judge the run from its log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module cpu_tb -f all.f -o cpu_sim \
    && ./obj_dir/cpu_sim > sim.log 2>&1 \
    || echo "build or simulation returned an error status" >> sim.log
cat sim.log
grep -q "TESTBENCH FAILED" sim.log && echo "RESULT: FAIL" && exit 1
grep -q "TESTBENCH PASSED" sim.log && echo "RESULT: PASS" && exit 0
echo "RESULT: FAIL, no result line in sim.log"
exit 1

// File: verification/cpu_tb.sv
`timescale 1ns/1ns
`default_nettype none

module cpu_tb import cpu_pkg::*; ();

    localparam int PROG_LEN   = 32;
    localparam int N_EXP      = 9;
    localparam int N_STALLS   = 3;              // tight LDD followed by a reader
    localparam int MAX_CYCLES = 20 * PROG_LEN + 200;

    typedef struct packed {
        data_t instr;
        data_t port;                            // in_port while offered
        logic  tight;                           // no idle gap after this word
    } prog_entry_t;

    logic  clk;
    logic  rst;
    logic  instr_valid;
    logic  instr_ready;
    data_t instr_data;
    data_t in_port;
    logic  out_valid;
    data_t out_data;

    int          beats_seen   = 0;
    int          stall_cycles = 0;
    int          cycle_count  = 0;
    int unsigned lcg_state;

    prog_entry_t prog [PROG_LEN] = '{
        '{8'h80, 8'h00, 1'b0},                  // LDM r0
        '{8'h5A, 8'h00, 1'b0},                  // r0 = 5a
        '{8'h70, 8'h00, 1'b0},                  // OUT r0 -> 5a
        '{8'h64, 8'hC3, 1'b0},                  // IN r1 = c3
        '{8'h71, 8'h00, 1'b0},                  // OUT r1 -> c3
        '{8'h88, 8'h00, 1'b0},                  // LDM r2
        '{8'hF0, 8'h00, 1'b1},                  // r2 = f0
        '{8'h29, 8'h00, 1'b1},                  // ADD r2,r1 = b3
        '{8'h38, 8'h00, 1'b1},                  // SUB r2,r0 = 59
        '{8'h49, 8'h00, 1'b1},                  // AND r2,r1 = 41
        '{8'h58, 8'h00, 1'b1},                  // OR r2,r0 = 5b
        '{8'h1E, 8'h00, 1'b1},                  // MOV r3,r2 = 5b
        '{8'h73, 8'h00, 1'b1},                  // OUT r3 -> 5b
        '{8'h33, 8'h00, 1'b0},                  // SUB r0,r3 = ff, two behind MOV
        '{8'h70, 8'h00, 1'b0},                  // OUT r0 -> ff
        '{8'h25, 8'h00, 1'b1},                  // ADD r1,r1 = 86
        '{8'h00, 8'h00, 1'b1},                  // NOP
        '{8'h71, 8'h00, 1'b0},                  // OUT r1 -> 86
        '{8'h84, 8'h00, 1'b0},                  // LDM r1
        '{8'h07, 8'h00, 1'b0},                  // r1 = 07, the address
        '{8'h88, 8'h00, 1'b0},                  // LDM r2
        '{8'h3C, 8'h00, 1'b1},                  // r2 = 3c
        '{8'hA9, 8'h00, 1'b1},                  // STD r2,[r1]
        '{8'h9D, 8'h00, 1'b1},                  // LDD r3,[r1]
        '{8'h73, 8'h00, 1'b0},                  // OUT r3 -> 3c, stalls
        '{8'h91, 8'h00, 1'b1},                  // LDD r0,[r1]
        '{8'h20, 8'h00, 1'b0},                  // ADD r0,r0 = 78, stalls
        '{8'h70, 8'h00, 1'b0},                  // OUT r0 -> 78
        '{8'h9A, 8'h00, 1'b1},                  // LDD r2,[r2] never written
        '{8'h72, 8'h00, 1'b0},                  // OUT r2 -> 00, stalls
        '{8'h6C, 8'h5E, 1'b0},                  // IN r3 = 5e
        '{8'h73, 8'h00, 1'b0}                   // OUT r3 -> 5e
    };

    data_t expected [N_EXP] = '{
        8'h5A, 8'hC3, 8'h5B, 8'hFF, 8'h86, 8'h3C, 8'h78, 8'h00, 8'h5E
    };

    cpu_top #(
        .DMEM_ADDR_W (8)
    ) dut0 (
        .clk         (clk),
        .rst         (rst),
        .instr_valid (instr_valid),
        .instr_ready (instr_ready),
        .instr_data  (instr_data),
        .in_port     (in_port),
        .out_valid   (out_valid),
        .out_data    (out_data)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;                 // 40 ns period
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("TESTBENCH FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_data(input data_t got, input data_t exp, input string what);
        if (got !== exp) begin
            fail_run($sformatf("mismatch at %0t ns: %s got 0x%02h expected 0x%02h",
                               $time, what, got, exp));
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            fail_run($sformatf("mismatch at %0t ns: %s got %b expected %b",
                               $time, what, got, exp));
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got != exp) begin
            fail_run($sformatf("mismatch at %0t ns: %s counted %0d expected %0d",
                               $time, what, got, exp));
        end
    endtask

    function automatic int unsigned lcg_next(input int unsigned s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // OUT words in the table, skipping LDM values
    function automatic int count_out_words();
        int   n;
        logic imm_next;
        n = 0;
        imm_next = 1'b0;
        for (int i = 0; i < PROG_LEN; i++) begin
            if (imm_next) begin
                imm_next = 1'b0;                // data word, not an opcode
            end else if (prog[i].instr[7:4] == OP_OUT) begin
                n++;
            end else if (prog[i].instr[7:4] == OP_LDM) begin
                imm_next = 1'b1;
            end
        end
        return n;
    endfunction

    // offer one word and wait until it is taken
    task automatic offer_word(input data_t word, input data_t port_val);
        logic taken;
        taken       = 1'b0;
        instr_valid = 1'b1;
        instr_data  = word;
        in_port     = port_val;
        while (!taken) begin
            @(negedge clk);
            taken = instr_ready;                // ready only moves at posedge
            @(posedge clk);
            #2;
        end
        instr_valid = 1'b0;
    endtask

    // output and stall monitor, sampled mid-cycle
    always @(negedge clk) begin
        if (!rst && out_valid) begin
            if (beats_seen >= N_EXP) begin
                fail_run("an output beat arrived after all expected values were seen");
            end else begin
                check_data(out_data, expected[beats_seen],
                           $sformatf("out beat %0d", beats_seen));
                beats_seen++;
            end
        end
        if (!rst && !instr_ready) begin
            stall_cycles++;
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > MAX_CYCLES) begin
            fail_run($sformatf("timeout, run did not finish within %0d cycles", MAX_CYCLES));
        end
    end

    initial begin
        int gap;
        int drain;
        rst         = 1'b1;
        instr_valid = 1'b0;
        instr_data  = '0;
        in_port     = '0;
        lcg_state   = 32'd10;                   // seed
        repeat (16) @(posedge clk);
        #2;
        rst = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        check_flag(instr_ready, 1'b1, "instr_ready after reset");
        check_flag(out_valid, 1'b0, "out_valid after reset");
        @(posedge clk);
        #2;
        for (int i = 0; i < PROG_LEN; i++) begin
            offer_word(prog[i].instr, prog[i].port);
            if (!prog[i].tight) begin
                lcg_state = lcg_next(lcg_state);
                gap = int'((lcg_state >> 16) % 4);  // 0..3 idle cycles
                repeat (gap) begin
                    @(posedge clk);
                    #2;
                end
            end
        end
        drain = 0;
        while (beats_seen < N_EXP && drain < 40) begin
            @(posedge clk);
            drain++;
        end
        repeat (8) @(posedge clk);              // catch any extra beat
        if (beats_seen < N_EXP) begin
            fail_run($sformatf("only %0d of %0d expected outputs appeared",
                               beats_seen, N_EXP));
        end
        check_count(count_out_words(), N_EXP, "OUT words in program");
        check_count(stall_cycles, N_STALLS, "cycles with instr_ready low");
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: verification/cpu_tb_assert.sv
`timescale 1ns/1ns
`default_nettype none

module cpu_tb_assert import cpu_pkg::*; (
    input logic  clk,
    input logic  rst,
    input logic  instr_valid,
    input logic  instr_ready,
    input data_t instr_data,
    input logic  out_valid
);

    // pipeline registers are cleared after the first reset edge
    a_quiet_in_reset: assert property (
        @(posedge clk) (rst && $past(rst)) |-> !out_valid
    ) else $error("out_valid high during reset");

    // a load-use stall lasts one cycle only
    a_single_stall: assert property (
        @(posedge clk) disable iff (rst) !instr_ready |=> instr_ready
    ) else $error("instr_ready low on two cycles in a row");

    a_offer_stable: assert property (
        @(posedge clk) disable iff (rst)
        (instr_valid && !instr_ready) |=> (instr_valid && $stable(instr_data))
    ) else $error("pending instruction word changed before it was taken");

endmodule

bind cpu_top cpu_tb_assert u_tb_assert (
    .clk         (clk),
    .rst         (rst),
    .instr_valid (instr_valid),
    .instr_ready (instr_ready),
    .instr_data  (instr_data),
    .out_valid   (out_valid)
);

`default_nettype wire

// File: verilog/cpu_top.sv
`timescale 1ns/1ns
`default_nettype none

module cpu_top import cpu_pkg::*; #(
    parameter int DMEM_ADDR_W = 8               // data memory address bits
) (
    input  logic  clk,
    input  logic  rst,
    input  logic  instr_valid,
    output logic  instr_ready,
    input  data_t instr_data,
    input  data_t in_port,
    output logic  out_valid,
    output data_t out_data
);

    if_id_t   if_id;                            // fetch -> decode
    id_ex_t   id_ex;                            // decode -> execute
    ex_mem_t  ex_mem;                           // execute -> memory
    mem_wb_t  mem_wb;                           // memory -> execute (fwd)
    logic     hold;                             // load-use stall
    reg_idx_t rd_idx_a;
    reg_idx_t rd_idx_b;
    data_t    rd_data_a;
    data_t    rd_data_b;
    logic     wb_en;
    reg_idx_t wb_idx;
    data_t    wb_data;

    fetch_stage u_fetch (
        .clk         (clk),
        .rst         (rst),
        .instr_valid (instr_valid),
        .instr_ready (instr_ready),
        .instr_data  (instr_data),
        .in_port     (in_port),
        .hold        (hold),
        .if_id       (if_id)
    );

    decode_stage u_decode (
        .clk       (clk),
        .rst       (rst),
        .if_id     (if_id),
        .hold      (hold),
        .rd_idx_a  (rd_idx_a),
        .rd_idx_b  (rd_idx_b),
        .rd_data_a (rd_data_a),
        .rd_data_b (rd_data_b),
        .id_ex     (id_ex)
    );

    register_file u_regfile (
        .clk       (clk),
        .rst       (rst),
        .rd_idx_a  (rd_idx_a),
        .rd_idx_b  (rd_idx_b),
        .rd_data_a (rd_data_a),
        .rd_data_b (rd_data_b),
        .wb_en     (wb_en),                     // from MEM/WB
        .wb_idx    (wb_idx),
        .wb_data   (wb_data)
    );

    execute_stage u_execute (
        .clk    (clk),
        .rst    (rst),
        .id_ex  (id_ex),
        .mem_wb (mem_wb),
        .ex_mem (ex_mem)
    );

    memory_stage #(
        .DMEM_ADDR_W (DMEM_ADDR_W)
    ) u_memory (
        .clk       (clk),
        .rst       (rst),
        .ex_mem    (ex_mem),
        .mem_wb    (mem_wb),
        .wb_en     (wb_en),
        .wb_idx    (wb_idx),
        .wb_data   (wb_data),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

endmodule

`default_nettype wire

// File: verilog/fetch_stage.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_stage import cpu_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   instr_valid,
    output logic   instr_ready,
    input  data_t  instr_data,
    input  data_t  in_port,
    input  logic   hold,                        // decode stall request
    output if_id_t if_id
);

    logic accept;                               // word transfers this edge

    // only the load-use stall pushes back
    assign instr_ready = !hold;
    assign accept      = instr_valid && instr_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            if_id <= '0;
        end else if (!hold) begin               // hold keeps IF/ID as is
            if_id.valid <= accept;              // bubble when nothing offered
            if (accept) begin
                if_id.instr     <= instr_data;
                if_id.in_sample <= in_port;     // IN uses the value seen here
            end
        end
    end

endmodule

`default_nettype wire
